// ==== list.f ====
source/assertPkg.sv
source/threadDispatch.sv
source/windowThread.sv
source/resultCollect.sv
source/apbRegs.sv
source/propertyChecker.sv
tb/propertyChecker_tb.sv
tb/propertyChecker_props.sv

// ==== source/apbRegs.sv ====
//**************************************************************************
// APB control and status registers
//**************************************************************************
`timescale 1ns/10ps

module apbRegs (
   input  logic              Clk,
   input  logic              arstN,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  assertPkg::apbAddrT paddr,
   input  assertPkg::apbDataT pwdata,
   input  assertPkg::countT   passCount,
   input  assertPkg::countT   failCount,
   input  assertPkg::countT   ovflCount,
   output assertPkg::apbDataT prdata,
   output logic              pslverr,
   output logic              enable,
   output logic              clear
);

   import assertPkg::*;

   logic access;     // access phase, no wait states
   logic mapped;
   logic ctrlWrite;

   assign access = psel && penable;

   always_comb begin
      case (paddr)
         ctrlAddr, passAddr, failAddr, ovflAddr: mapped = 1'b1;
         default:                                mapped = 1'b0;
      endcase
   end

   assign pslverr   = access && !mapped;
   assign ctrlWrite = access && pwrite && (paddr == ctrlAddr);

   // enable holds, clear lasts one cycle after the write
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         enable <= 1'b0;
         clear  <= 1'b0;
      end
      else begin
         clear <= ctrlWrite && pwdata[clearBit];
         if (ctrlWrite) begin
            enable <= pwdata[enableBit];
         end
      end
   end

   // read mux, counters zero extended
   always_comb begin
      prdata = '0;
      if (access && !pwrite) begin
         case (paddr)
            ctrlAddr: prdata[enableBit] = enable;   // clear bit reads 0
            passAddr: prdata = apbDataT'(passCount);
            failAddr: prdata = apbDataT'(failCount);
            ovflAddr: prdata = apbDataT'(ovflCount);
            default:  prdata = '0;
         endcase
      end
   end

endmodule

// ==== source/assertPkg.sv ====
//**************************************************************************
// Property checker shared definitions
//**************************************************************************

package assertPkg;

   // APB bus widths
   typedef logic [7:0]  apbAddrT;
   typedef logic [31:0] apbDataT;

   typedef logic [15:0] countT;   // event counters, wrap on overflow

   // per-thread age, so dlyMax can be 14 at most
   typedef logic [3:0]  ageT;

   // register map
   localparam apbAddrT ctrlAddr = 8'h00;
   localparam apbAddrT passAddr = 8'h04;
   localparam apbAddrT failAddr = 8'h08;
   localparam apbAddrT ovflAddr = 8'h0C;

   // control register fields
   localparam int enableBit = 0;
   localparam int clearBit  = 1;   // self clearing, reads back 0

endpackage

// ==== source/propertyChecker.sv ====
//**************************************************************************
// Req to ack window property checker
//**************************************************************************
`timescale 1ns/10ps

module propertyChecker #(
   parameter int numThreads = 2,
   parameter int dlyMin     = 2,   // at least 1
   parameter int dlyMax     = 6    // dlyMin up to 14
) (
   input  logic              Clk,
   input  logic              arstN,
   input  logic              req,
   input  logic              ack,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  assertPkg::apbAddrT paddr,
   input  assertPkg::apbDataT pwdata,
   output assertPkg::apbDataT prdata,
   output logic              pslverr,
   output logic              checkPass,
   output logic              checkFail
);

   import assertPkg::*;

   logic enable;
   logic clear;
   logic overflow;
   logic [numThreads-1:0] start;
   logic [numThreads-1:0] busy;
   logic [numThreads-1:0] passHit;
   logic [numThreads-1:0] failHit;
   countT passCount;
   countT failCount;
   countT ovflCount;

   apbRegs uRegs (
      .Clk(Clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .passCount(passCount), .failCount(failCount),
      .ovflCount(ovflCount), .prdata(prdata), .pslverr(pslverr),
      .enable(enable), .clear(clear));

   threadDispatch #(.numThreads(numThreads)) uDispatch (
      .Clk(Clk), .arstN(arstN), .enable(enable), .clear(clear), .req(req),
      .busy(busy), .start(start), .overflow(overflow));

   // one window counter per outstanding attempt
   for (genvar i = 0; i < numThreads; i++) begin : gThread
      windowThread #(.dlyMin(dlyMin), .dlyMax(dlyMax)) uThread (
         .Clk(Clk), .arstN(arstN), .enable(enable), .clear(clear),
         .start(start[i]), .ack(ack), .busy(busy[i]),
         .passHit(passHit[i]), .failHit(failHit[i]));
   end

   resultCollect #(.numThreads(numThreads)) uCollect (
      .Clk(Clk), .arstN(arstN), .clear(clear), .overflow(overflow),
      .passHit(passHit), .failHit(failHit), .checkPass(checkPass),
      .checkFail(checkFail), .passCount(passCount), .failCount(failCount),
      .ovflCount(ovflCount));

endmodule

// ==== source/resultCollect.sv ====
//**************************************************************************
// Result pulses and event counters
//**************************************************************************
`timescale 1ns/10ps

module resultCollect #(
   parameter int numThreads = 2
) (
   input  logic                  Clk,
   input  logic                  arstN,
   input  logic                  clear,
   input  logic                  overflow,
   input  logic [numThreads-1:0] passHit,
   input  logic [numThreads-1:0] failHit,
   output logic                  checkPass,
   output logic                  checkFail,
   output assertPkg::countT      passCount,
   output assertPkg::countT      failCount,
   output assertPkg::countT      ovflCount
);

   import assertPkg::*;

   // number of threads deciding this cycle
   function automatic countT popCount(input logic [numThreads-1:0] hits);
      countT n;
      n = '0;
      for (int i = 0; i < numThreads; i++) begin
         n = n + countT'(hits[i]);
      end
      return n;
   endfunction

   // one pulse even when several threads decide together
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         checkPass <= 1'b0;
         checkFail <= 1'b0;
      end
      else if (clear) begin
         checkPass <= 1'b0;
         checkFail <= 1'b0;
      end
      else begin
         checkPass <= |passHit;
         checkFail <= |failHit;
      end
   end

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         passCount <= '0;
         failCount <= '0;
         ovflCount <= '0;
      end
      else if (clear) begin
         passCount <= '0;
         failCount <= '0;
         ovflCount <= '0;
      end
      else begin
         passCount <= passCount + popCount(passHit);   // counters wrap
         failCount <= failCount + popCount(failHit);
         ovflCount <= ovflCount + countT'(overflow);
      end
   end

endmodule

// ==== source/threadDispatch.sv ====
//**************************************************************************
// Rise detect and thread dispatch
//**************************************************************************
`timescale 1ns/10ps

module threadDispatch #(
   parameter int numThreads = 2
) (
   input  logic                  Clk,
   input  logic                  arstN,
   input  logic                  enable,
   input  logic                  clear,
   input  logic                  req,
   input  logic [numThreads-1:0] busy,
   output logic [numThreads-1:0] start,
   output logic                  overflow
);

   logic reqQ;     // req as sampled last cycle
   logic trigger;

   // history keeps running even while disabled
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         reqQ <= 1'b0;
      end
      else begin
         reqQ <= req;
      end
   end

   // a rise only counts while enabled and not clearing
   assign trigger = enable && !clear && req && !reqQ;

   // lowest idle thread takes the attempt
   always_comb begin
      logic taken;
      taken = 1'b0;
      start = '0;
      for (int i = 0; i < numThreads; i++) begin
         if (trigger && !busy[i] && !taken) begin
            start[i] = 1'b1;
            taken    = 1'b1;
         end
      end
   end

   // no thread left, attempt is dropped
   assign overflow = trigger && (&busy);

endmodule

// ==== source/windowThread.sv ====
//**************************************************************************
// Window thread
//**************************************************************************
`timescale 1ns/10ps

module windowThread #(
   parameter int dlyMin = 2,
   parameter int dlyMax = 6
) (
   input  logic Clk,
   input  logic arstN,
   input  logic enable,
   input  logic clear,
   input  logic start,
   input  logic ack,
   output logic busy,
   output logic passHit,
   output logic failHit
);

   import assertPkg::*;

   ageT age;   // cycles since the trigger, 0 when idle
   logic active;

   // no decision while clearing or disabled
   assign active = enable && !clear;

   assign busy    = (age != '0);
   assign passHit = active && busy && (age >= ageT'(dlyMin)) && ack;
   assign failHit = active && (age == ageT'(dlyMax)) && !ack;

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         age <= '0;
      end
      else if (!active) begin
         age <= '0;             // drop attempt in flight
      end
      else if (start) begin
         age <= ageT'(1);
      end
      else if (busy) begin
         if (passHit || failHit) begin
            age <= '0;          // decided, thread is free next cycle
         end
         else begin
            age <= age + ageT'(1);
         end
      end
   end

endmodule

// ==== tb/propertyChecker_props.sv ====
//**************************************************************************
// Property checker assertions
//**************************************************************************
`timescale 1ns/10ps

module propertyChecker_props (
   input logic Clk,
   input logic arstN,
   input logic psel,
   input logic penable,
   input logic pslverr,
   input logic clear,
   input logic checkPass,
   input logic checkFail
);

   // ack cannot be high and low at once
   pulsesExclusive: assert property (@(posedge Clk) disable iff (!arstN)
      !(checkPass && checkFail))
      else $error("checkPass and checkFail are high together");

   slverrInAccess: assert property (@(posedge Clk) disable iff (!arstN)
      pslverr |-> (psel && penable))
      else $error("pslverr is high outside an access phase");

   // clear drops attempts without a result
   quietAfterClear: assert property (@(posedge Clk) disable iff (!arstN)
      clear |=> (!checkPass && !checkFail))
      else $error("result pulse in the cycle after clear");

endmodule

bind propertyChecker propertyChecker_props uProps (
   .Clk(Clk), .arstN(arstN), .psel(psel), .penable(penable), .pslverr(pslverr),
   .clear(clear), .checkPass(checkPass), .checkFail(checkFail));

// ==== tb/propertyChecker_tb.sv ====
//**************************************************************************
// Property checker testbench
//**************************************************************************
`timescale 1ns/10ps

module propertyChecker_tb;

   import assertPkg::*;

   localparam int numThreads = 2;
   localparam int dlyMin     = 2;
   localparam int dlyMax     = 6;

   // test lengths in cycles, used by the watchdog
   localparam int lenRegs    = 80;
   localparam int lenSingle  = 200;
   localparam int lenOverlap = 150;
   localparam int lenRandom  = 2100;
   localparam int lenClear   = 250;
   localparam int timeoutCycles = 8 + lenRegs + lenSingle + lenOverlap + lenRandom
                                  + lenClear + 500;

   logic Clk = 1'b0;
   logic arstN;
   logic req;
   logic ack;
   logic psel;
   logic penable;
   logic pwrite;
   apbAddrT paddr;
   apbDataT pwdata;
   apbDataT prdata;
   logic pslverr;
   logic checkPass;
   logic checkFail;

   // reference model state
   logic  mReqQ;
   logic  mEnable;
   logic  mClear;
   ageT   mAge [numThreads];
   logic  mPass;
   logic  mFail;
   countT mPassCnt;
   countT mFailCnt;
   countT mOvflCnt;

   string testName = "reset";
   int    errors = 0;
   int    checks = 0;
   int    testCount = 0;
   int    errAtStart = 0;
   int    seed;
   int    ackOffsets [5] = '{1, 2, 4, 6, 7};   // before, inside, edge, after window

   propertyChecker #(.numThreads(numThreads), .dlyMin(dlyMin), .dlyMax(dlyMax)) dut (
      .Clk(Clk), .arstN(arstN), .req(req), .ack(ack), .psel(psel), .penable(penable),
      .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
      .pslverr(pslverr), .checkPass(checkPass), .checkFail(checkFail));

   always #5 Clk = ~Clk;

   function automatic void modelReset();
      mReqQ    = 1'b0;
      mEnable  = 1'b0;
      mClear   = 1'b0;
      mPass    = 1'b0;
      mFail    = 1'b0;
      mPassCnt = '0;
      mFailCnt = '0;
      mOvflCnt = '0;
      for (int i = 0; i < numThreads; i++) begin
         mAge[i] = '0;
      end
   endfunction

   // one clock of the property rules, inputs as sampled at the coming edge
   function automatic void modelStep(input logic reqIn, input logic ackIn,
                                     input logic ctrlWr, input apbDataT wdata);
      logic active;
      logic trigger;
      logic placed;
      logic allBusy;
      int   nPass;
      int   nFail;
      ageT  nextAge [numThreads];
      active  = mEnable && !mClear;
      trigger = active && reqIn && !mReqQ;
      placed  = 1'b0;
      allBusy = 1'b1;
      nPass   = 0;
      nFail   = 0;
      for (int i = 0; i < numThreads; i++) begin
         nextAge[i] = '0;
         if (mAge[i] == '0) begin
            allBusy = 1'b0;
            if (trigger && !placed) begin   // lowest free thread
               nextAge[i] = ageT'(1);
               placed     = 1'b1;
            end
         end
         else if (ackIn && mAge[i] >= dlyMin) begin
            nPass++;
         end
         else if (mAge[i] == dlyMax) begin
            nFail++;
         end
         else begin
            nextAge[i] = mAge[i] + ageT'(1);
         end
         if (!active) begin
            nextAge[i] = '0;
         end
      end
      if (mClear) begin
         mPass    = 1'b0;
         mFail    = 1'b0;
         mPassCnt = '0;
         mFailCnt = '0;
         mOvflCnt = '0;
      end
      else begin
         mPass    = active && (nPass > 0);
         mFail    = active && (nFail > 0);
         mPassCnt = mPassCnt + (active ? countT'(nPass) : countT'(0));
         mFailCnt = mFailCnt + (active ? countT'(nFail) : countT'(0));
         mOvflCnt = mOvflCnt + countT'(trigger && allBusy);
      end
      mAge   = nextAge;
      mReqQ  = reqIn;
      mClear = ctrlWr && wdata[clearBit];
      if (ctrlWr) begin
         mEnable = wdata[enableBit];
      end
   endfunction

   task automatic compareBit(input string what, input logic expVal, input logic actVal);
      checks++;
      if (actVal !== expVal) begin
         errors++;
         $display("FAILED %s %s expected %0b actual %0b", testName, what, expVal, actVal);
      end
   endtask

   task automatic compareCount(input string what, input countT expVal, input countT actVal);
      checks++;
      if (actVal !== expVal) begin
         errors++;
         $display("FAILED %s %s expected %0d actual %0d", testName, what, expVal, actVal);
      end
   endtask

   task automatic compareData(input string what, input apbDataT expVal, input apbDataT actVal);
      checks++;
      if (actVal !== expVal) begin
         errors++;
         $display("FAILED %s %s expected 'h%08h actual 'h%08h", testName, what, expVal, actVal);
      end
   endtask

   // pulses checked against the model every cycle, at the falling edge
   always @(negedge Clk) begin
      if (!arstN) begin
         modelReset();
      end
      else begin
         compareBit("checkPass", mPass, checkPass);
         compareBit("checkFail", mFail, checkFail);
         modelStep(req, ack, psel && penable && pwrite && (paddr == ctrlAddr), pwdata);
      end
   end

   task automatic apbWrite(input apbAddrT addr, input apbDataT data);
      @(posedge Clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge Clk);
      penable <= 1'b1;
      @(posedge Clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
      @(posedge Clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge Clk);
      penable <= 1'b1;
      @(negedge Clk);   // mid access phase
      data = prdata;
      err  = pslverr;
      @(posedge Clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic readCount(input apbAddrT addr, output countT val);
      apbDataT data;
      logic err;
      apbRead(addr, data, err);
      compareBit("counter pslverr", 1'b0, err);
      compareData("counter upper bits", '0, data & 32'hFFFF_0000);
      val = countT'(data);
   endtask

   task automatic checkCounters();
      countT val;
      readCount(passAddr, val);
      compareCount("passCount", mPassCnt, val);
      readCount(failAddr, val);
      compareCount("failCount", mFailCnt, val);
      readCount(ovflAddr, val);
      compareCount("ovflCount", mOvflCnt, val);
   endtask

   // bit c of each vector goes out at the c-th rising edge
   task automatic drivePattern(input logic [31:0] reqBits, input logic [31:0] ackBits,
                               input int len);
      for (int c = 0; c < len; c++) begin
         @(posedge Clk);
         req <= reqBits[c];
         ack <= ackBits[c];
      end
   endtask

   task automatic settle();
      repeat (dlyMax + 4) @(posedge Clk);
   endtask

   task automatic startTest(input string name);
      testName   = name;
      errAtStart = errors;
      testCount++;
   endtask

   task automatic endTest();
      $display("test %-8s finished with %0d errors", testName, errors - errAtStart);
   endtask

   initial begin
      repeat (timeoutCycles) @(posedge Clk);
      $display("watchdog expired after %0d cycles, the run did not finish", timeoutCycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      apbDataT data;
      logic    err;
      countT   val;
      countT   heldPass;
      countT   heldFail;
      countT   heldOvfl;
      seed    = 72925;
      void'($urandom(seed));
      arstN   = 1'b0;
      req     = 1'b0;
      ack     = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (8) @(posedge Clk);
      arstN <= 1'b1;

      startTest("regs");
      checkCounters();
      apbRead(ctrlAddr, data, err);
      compareData("ctrl after reset", '0, data);
      compareBit("ctrl pslverr", 1'b0, err);
      apbWrite(ctrlAddr, 32'h1);
      apbRead(ctrlAddr, data, err);
      compareData("ctrl enabled", 32'h1, data);
      apbWrite(passAddr, 32'h5);   // read-only, ignored
      checkCounters();
      apbRead(8'h10, data, err);
      compareBit("unmapped pslverr", 1'b1, err);
      compareData("unmapped data", '0, data);
      endTest();

      startTest("single");
      foreach (ackOffsets[i]) begin
         drivePattern(32'h1, 32'h1 << ackOffsets[i], 16);
         checkCounters();
      end
      readCount(passAddr, val);
      compareCount("passes in window", countT'(3), val);
      readCount(failAddr, val);
      compareCount("misses of window", countT'(2), val);
      endTest();

      startTest("overlap");
      drivePattern(32'b10101, '0, 20);             // third rise finds no thread
      checkCounters();
      drivePattern(32'b101, 32'h1 << 4, 20);       // both threads pass together
      checkCounters();
      endTest();

      startTest("random");
      for (int c = 0; c < 2000; c++) begin
         @(posedge Clk);
         req <= ($urandom % 3) == 0;
         ack <= ($urandom % 4) == 0;
      end
      @(posedge Clk);
      req <= 1'b0;
      ack <= 1'b0;
      settle();
      checkCounters();
      endTest();

      startTest("disable");
      drivePattern(32'h1, '0, 2);   // attempt in flight when disabled
      apbWrite(ctrlAddr, 32'h0);
      heldPass = mPassCnt;
      heldFail = mFailCnt;
      heldOvfl = mOvflCnt;
      drivePattern(32'b10101, 32'h1 << 3, 20);
      readCount(passAddr, val);
      compareCount("passCount held", heldPass, val);
      readCount(failAddr, val);
      compareCount("failCount held", heldFail, val);
      readCount(ovflAddr, val);
      compareCount("ovflCount held", heldOvfl, val);
      apbWrite(ctrlAddr, 32'h1);
      drivePattern(32'h1, '0, 2);
      apbWrite(ctrlAddr, 32'h3);   // clear while the attempt is in flight
      settle();
      readCount(passAddr, val);
      compareCount("passCount cleared", '0, val);
      readCount(failAddr, val);
      compareCount("failCount cleared", '0, val);
      readCount(ovflAddr, val);
      compareCount("ovflCount cleared", '0, val);
      checkCounters();
      apbRead(ctrlAddr, data, err);
      compareData("ctrl after clear", 32'h1, data);
      endTest();

      $display("tests run %0d, checks %0d, errors %0d", testCount, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end
      else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
